// ==== vlog.f ====
+incdir+common
common/uart_rx_pkg.sv
uart_receiver/uart_frame_receiver.sv
logic/rx_credit_fifo.sv
logic/rx_register_port.sv
logic/uart_rx_top.sv
verification/uart_rx_chk.sv
verification/uart_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run the UART receive testbench.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module uart_rx_tb -Mdir obj_dir -o uart_rx_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/uart_rx_sim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== verification/uart_rx_tb.sv ====
// Expects reads to reach o_ready three falling edges after req; bit timing follows the defines header.
`timescale 1ns/1ps
`include "uart_rx_defines.svh"

module uart_rx_tb import uart_rx_pkg::*; ();
	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int DEPTH = `UART_FIFO_DEPTH;
	localparam int PERIOD_NS = 40;
	localparam int READY_LATENCY = 3;
	localparam int READY_LIMIT = 20;

	localparam logic [2:0] ACT_SEND = 3'd0;
	localparam logic [2:0] ACT_READ_DATA = 3'd1;
	localparam logic [2:0] ACT_READ_STATUS = 3'd2;
	localparam logic [2:0] ACT_GLITCH = 3'd3;
	localparam logic [2:0] ACT_COUNT_IRQ = 3'd4;
	localparam logic [2:0] ACT_COUNT_SOFT = 3'd5;

	localparam logic [31:0] ST_OVERRUN = 32'h1;
	localparam logic [31:0] ST_EMPTY = 32'h2;
	localparam logic [31:0] ST_FRAMING = 32'h4;

	// One row of the stimulus table.
	typedef struct packed {
		logic [2:0]  test;
		logic [2:0]  action;
		logic [7:0]  data;
		logic        stop;
		logic [31:0] expected;
	} step_t;

	logic        i_clock;
	logic        i_reset;
	logic        i_serial;
	bus_req_t    i_bus;
	logic [31:0] o_rdata;
	logic        o_ready;
	logic        o_interrupt;
	logic        o_soft_reset;

	step_t      steps [$];
	integer     seed;
	int         errors = 0;
	int         checks = 0;
	int         irq_total = 0;
	int         soft_total = 0;
	int         irq_start;
	int         soft_start;
	int         errors_start;
	int         checks_start;
	logic [2:0] cur_test;
	logic [7:0] burst [DEPTH + 2];

	uart_rx_top uart_rx_top_inst (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_serial     (i_serial),
		.i_bus        (i_bus),
		.o_rdata      (o_rdata),
		.o_ready      (o_ready),
		.o_interrupt  (o_interrupt),
		.o_soft_reset (o_soft_reset)
	);

	initial i_clock = 1'b0;
	always #(PERIOD_NS / 2) i_clock = ~i_clock;

	// Pulse counters, sampled before the edge updates the outputs.
	always @(posedge i_clock) begin
		if (!i_reset && o_interrupt) begin
			irq_total <= irq_total + 1;
		end
		if (!i_reset && o_soft_reset) begin
			soft_total <= soft_total + 1;
		end
	end

	task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("ERR time=%0t signal=%s expected=0x%08h actual=0x%08h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	function automatic logic [31:0] data_word(input logic [7:0] value);
		// Bit 8 marks a byte that was present.
		return 32'h0000_0100 | 32'(value);
	endfunction

	task add_step(input logic [2:0] test, input logic [2:0] action, input logic [7:0] data,
		input logic stop, input logic [31:0] expected);
		step_t row;
		row.test = test;
		row.action = action;
		row.data = data;
		row.stop = stop;
		row.expected = expected;
		steps.push_back(row);
	endtask

	task drive_bit(input logic level);
		i_serial = level;
		repeat (CLKS) @(negedge i_clock);
	endtask

	task send_frame(input logic [7:0] data, input logic stop_level);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			drive_bit(data[i]);
		end
		drive_bit(stop_level);
		// Idle gap before the next frame.
		drive_bit(1'b1);
	endtask

	task send_glitch();
		i_serial = 1'b0;
		repeat (CLKS / 4) @(negedge i_clock);
		i_serial = 1'b1;
		// Long enough for a false start to run through a whole frame.
		repeat (11 * CLKS) @(negedge i_clock);
	endtask

	task bus_read(input logic [1:0] addr, output logic [31:0] data);
		int waited;
		waited = 0;
		i_bus.addr = addr;
		i_bus.req = 1'b1;
		do begin
			@(negedge i_clock);
			waited++;
		end while (!o_ready && waited < READY_LIMIT);
		if (o_ready !== 1'b1) begin
			$display("Bus read at address %0d got no o_ready within %0d cycles", addr, READY_LIMIT);
			errors++;
		end else begin
			check_value("o_ready latency", READY_LATENCY, waited);
		end
		data = o_rdata;
		i_bus.req = 1'b0;
		// Request stays low at least one cycle between accesses.
		repeat (2) @(negedge i_clock);
	endtask

	task finish_test();
		$display("test %0d finished: %0d checks, %0d mismatches",
			cur_test, checks - checks_start, errors - errors_start);
	endtask

	task build_table();
		integer r;
		for (int i = 0; i < 3; i++) begin
			r = $random(seed);
			burst[i] = r[7:0];
			add_step(3'd1, ACT_SEND, burst[i], 1'b1, 32'd0);
		end
		for (int i = 0; i < 3; i++) begin
			add_step(3'd1, ACT_READ_DATA, 8'd0, 1'b1, data_word(burst[i]));
		end
		add_step(3'd1, ACT_COUNT_IRQ, 8'd0, 1'b1, 32'd3);
		add_step(3'd2, ACT_READ_STATUS, 8'd0, 1'b1, ST_EMPTY);
		add_step(3'd2, ACT_READ_DATA, 8'd0, 1'b1, 32'd0);
		// Two more bytes than the credits allow.
		for (int i = 0; i < DEPTH + 2; i++) begin
			r = $random(seed);
			burst[i] = r[7:0];
			add_step(3'd3, ACT_SEND, burst[i], 1'b1, 32'd0);
		end
		for (int i = 0; i < DEPTH; i++) begin
			add_step(3'd3, ACT_READ_DATA, 8'd0, 1'b1, data_word(burst[i]));
		end
		add_step(3'd3, ACT_READ_STATUS, 8'd0, 1'b1, ST_OVERRUN | ST_EMPTY);
		add_step(3'd3, ACT_READ_STATUS, 8'd0, 1'b1, ST_EMPTY);
		r = $random(seed);
		add_step(3'd4, ACT_SEND, r[7:0], 1'b0, 32'd0);
		add_step(3'd4, ACT_READ_DATA, 8'd0, 1'b1, 32'd0);
		add_step(3'd4, ACT_READ_STATUS, 8'd0, 1'b1, ST_FRAMING | ST_EMPTY);
		add_step(3'd5, ACT_SEND, 8'hFF, 1'b1, 32'd0);
		add_step(3'd5, ACT_COUNT_SOFT, 8'd0, 1'b1, 32'd1);
		add_step(3'd5, ACT_READ_DATA, 8'd0, 1'b1, data_word(8'hFF));
		add_step(3'd6, ACT_GLITCH, 8'd0, 1'b1, 32'd0);
		add_step(3'd6, ACT_COUNT_IRQ, 8'd0, 1'b1, 32'd0);
		add_step(3'd6, ACT_READ_STATUS, 8'd0, 1'b1, ST_EMPTY);
		r = $random(seed);
		add_step(3'd6, ACT_SEND, r[7:0], 1'b1, 32'd0);
		add_step(3'd6, ACT_READ_DATA, 8'd0, 1'b1, data_word(r[7:0]));
	endtask

	initial begin
		step_t       s;
		logic [31:0] rdata;
		seed = 6371;
		i_reset = 1'b1;
		i_serial = 1'b1;
		i_bus = '0;
		build_table();
		repeat (3) @(negedge i_clock);
		i_reset = 1'b0;
		repeat (2) @(negedge i_clock);
		cur_test = 3'd0;
		for (int i = 0; i < steps.size(); i++) begin
			s = steps[i];
			if (s.test != cur_test) begin
				if (cur_test != 3'd0) begin
					finish_test();
				end
				cur_test = s.test;
				checks_start = checks;
				errors_start = errors;
				irq_start = irq_total;
				soft_start = soft_total;
			end
			case (s.action)
				ACT_SEND: send_frame(s.data, s.stop);
				ACT_GLITCH: send_glitch();
				ACT_READ_DATA: begin
					bus_read(`UART_ADDR_DATA, rdata);
					check_value("o_rdata (data)", s.expected, rdata);
				end
				ACT_READ_STATUS: begin
					bus_read(`UART_ADDR_STATUS, rdata);
					check_value("o_rdata (status)", s.expected, rdata);
				end
				ACT_COUNT_IRQ: check_value("o_interrupt pulses", s.expected, irq_total - irq_start);
				ACT_COUNT_SOFT: check_value("o_soft_reset pulses", s.expected, soft_total - soft_start);
				default: begin
					$display("Stimulus table row %0d holds an unknown action", i);
					errors++;
				end
			endcase
		end
		finish_test();
		$display("Summary: %0d checks, %0d errors, %0d interrupts, %0d soft resets",
			checks, errors, irq_total, soft_total);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Each row needs at most about 12 bit periods.
	initial begin
		int limit_ns;
		#1;
		limit_ns = steps.size() * 12 * CLKS * PERIOD_NS + 20 * PERIOD_NS;
		#(limit_ns);
		$display("Timeout: the tests did not finish within %0d ns", limit_ns);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verification/uart_rx_chk.sv ====
// Bound to every rx_credit_fifo instance; the count width must follow the FIFO's DEPTH.
`timescale 1ns/1ps

module uart_rx_chk #(
	parameter int DEPTH = 8
) (
	input logic                         i_clock,
	input logic                         i_reset,
	input logic                         i_push_req,
	input logic                         i_pop_req,
	input logic                         i_empty,
	input logic [$clog2(DEPTH + 1)-1:0] i_count,
	input logic                         i_credit_return
);

	// Credits must keep the receiver from pushing into a full buffer.
	a_no_push_full: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_push_req && (i_count == ($clog2(DEPTH + 1))'(DEPTH))))
		else $error("FIFO push while full");

	// The register port pops only after seeing a byte.
	a_no_pop_empty: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_pop_req && i_empty))
		else $error("FIFO pop while empty");

	a_count_bound: assert property (@(posedge i_clock) disable iff (i_reset)
		i_count <= ($clog2(DEPTH + 1))'(DEPTH))
		else $error("FIFO occupancy above DEPTH");

	// One credit per pop, pops are spread out.
	a_credit_single: assert property (@(posedge i_clock) disable iff (i_reset)
		i_credit_return |=> !i_credit_return)
		else $error("Credit return high two cycles in a row");

endmodule

bind rx_credit_fifo uart_rx_chk #(
	.DEPTH (DEPTH)
) uart_rx_chk_inst (
	.i_clock         (i_clock),
	.i_reset         (i_reset),
	.i_push_req      (i_frame.valid),
	.i_pop_req       (i_pop),
	.i_empty         (o_empty),
	.i_count         (count),
	.i_credit_return (o_credit_return)
);

// ==== logic/uart_rx_top.sv ====
// Receive only; reads take exactly two cycles to o_ready and the baud rate is fixed at build time.
`timescale 1ns/1ps
`include "uart_rx_defines.svh"

module uart_rx_top import uart_rx_pkg::*; (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_serial,
	input  bus_req_t    i_bus,
	output logic [31:0] o_rdata,
	output logic        o_ready,
	output logic        o_interrupt,
	output logic        o_soft_reset
);
	rx_frame_t  frame;
	rx_event_t  rx_event;
	logic       credit_return;
	logic [7:0] fifo_head;
	logic       fifo_empty;
	logic       fifo_pop;

	uart_frame_receiver uart_frame_receiver_inst (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_serial        (i_serial),
		.i_credit_return (credit_return),
		.o_frame         (frame),
		.o_event         (rx_event)
	);

	// Depth must match the receiver's starting credit.
	rx_credit_fifo #(
		.DEPTH (`UART_FIFO_DEPTH)
	) rx_credit_fifo_inst (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_frame         (frame),
		.i_pop           (fifo_pop),
		.o_head          (fifo_head),
		.o_empty         (fifo_empty),
		.o_credit_return (credit_return)
	);

	rx_register_port rx_register_port_inst (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_bus        (i_bus),
		.i_head       (fifo_head),
		.i_empty      (fifo_empty),
		.i_event      (rx_event),
		.o_pop        (fifo_pop),
		.o_rdata      (o_rdata),
		.o_ready      (o_ready),
		.o_interrupt  (o_interrupt),
		.o_soft_reset (o_soft_reset)
	);

endmodule

// ==== logic/rx_register_port.sv ====
// Read-only port; the bus must hold req until o_ready and drop it for a cycle between accesses.
`timescale 1ns/1ps
`include "uart_rx_defines.svh"

module rx_register_port import uart_rx_pkg::*; (
	input  logic        i_clock,
	input  logic        i_reset,
	input  bus_req_t    i_bus,
	input  logic [7:0]  i_head,
	input  logic        i_empty,
	input  rx_event_t   i_event,
	output logic        o_pop,
	output logic [31:0] o_rdata,
	output logic        o_ready,
	output logic        o_interrupt,
	output logic        o_soft_reset
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_REPLY,
		ST_HOLD
	} port_state_t;

	port_state_t  state;
	logic         overrun_flag;
	logic         framing_flag;
	logic         is_data;
	logic         is_status;
	logic         clear_flags;
	status_bits_t status;

	assign is_data = (i_bus.addr == `UART_ADDR_DATA);
	assign is_status = (i_bus.addr == `UART_ADDR_STATUS);
	assign clear_flags = (state == ST_LOOKUP) && is_status;
	assign status = '{
		reserved: '0,
		framing_err: framing_flag,
		fifo_empty: i_empty,
		overrun: overrun_flag
	};

	// Idle, lookup, reply: o_ready rises two edges after req is seen.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_ready <= 1'b0;
			o_pop <= 1'b0;
		end else begin
			o_pop <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_bus.req) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					// Only one pop per access.
					o_pop <= is_data && !i_empty;
					state <= ST_REPLY;
				end
				ST_REPLY: begin
					o_ready <= 1'b1;
					state <= ST_HOLD;
				end
				ST_HOLD: begin
					if (!i_bus.req) begin
						o_ready <= 1'b0;
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == ST_LOOKUP) begin
			if (is_data && !i_empty) begin
				// Bit 8 flags a valid byte.
				o_rdata <= {23'd0, 1'b1, i_head};
			end else if (is_status) begin
				o_rdata <= status;
			end else begin
				o_rdata <= '0;
			end
		end
	end

	// A new event wins over a clear in the same cycle.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			overrun_flag <= 1'b0;
			framing_flag <= 1'b0;
			o_interrupt <= 1'b0;
			o_soft_reset <= 1'b0;
		end else begin
			overrun_flag <= (overrun_flag && !clear_flags) || i_event.overrun;
			framing_flag <= (framing_flag && !clear_flags) || i_event.framing_err;
			o_interrupt <= i_event.accepted;
			o_soft_reset <= i_event.soft_char;
		end
	end

endmodule

// ==== logic/rx_credit_fifo.sv ====
// Show-ahead FIFO; DEPTH need not be a power of two but must be at least 2.
`timescale 1ns/1ps
`include "uart_rx_defines.svh"

module rx_credit_fifo import uart_rx_pkg::*; #(
	parameter int DEPTH = `UART_FIFO_DEPTH
) (
	input  logic       i_clock,
	input  logic       i_reset,
	input  rx_frame_t  i_frame,
	input  logic       i_pop,
	output logic [7:0] o_head,
	output logic       o_empty,
	output logic       o_credit_return
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [7:0]    mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          push;
	logic          pop;
	logic          credit_q;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		if (ptr == AW'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign o_empty = (count == '0);
	// Credits keep the receiver from pushing into a full buffer.
	assign push = i_frame.valid;
	assign pop = i_pop && !o_empty;

	always_ff @(posedge i_clock) begin
		if (push) begin
			mem[wr_ptr] <= i_frame.data;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_q <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// The freed slot goes back as a credit.
			credit_q <= pop;
		end
	end

	// Oldest byte is always presented.
	assign o_head = mem[rd_ptr];
	assign o_credit_return = credit_q;

endmodule

// ==== uart_receiver/uart_frame_receiver.sv ====
// 8N1 only, LSB first; pushes only while credit remains, so bytes arriving with none are lost.
`timescale 1ns/1ps
`include "uart_rx_defines.svh"

module uart_frame_receiver import uart_rx_pkg::*; (
	input  logic      i_clock,
	input  logic      i_reset,
	input  logic      i_serial,
	input  logic      i_credit_return,
	output rx_frame_t o_frame,
	output rx_event_t o_event
);
	localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
	localparam int HALF_BIT = CLKS_PER_BIT / 2;
	localparam int CREDITS = `UART_FIFO_DEPTH;
	localparam int PW = $clog2(CLKS_PER_BIT);
	localparam int CW = $clog2(CREDITS + 1);

	// Bit index counts down through the frame.
	// 10 is the start bit, 9 to 2 the data bits, 1 the stop bit.
	localparam logic [3:0] IDX_IDLE = 4'd0;
	localparam logic [3:0] IDX_STOP = 4'd1;
	localparam logic [3:0] IDX_START = 4'd10;

	logic          sync_1;
	logic          sync_2;
	logic [PW-1:0] prescale;
	logic [3:0]    bit_idx;
	logic [7:0]    shift_data;
	logic [CW-1:0] credits;
	logic          push_q;
	rx_event_t     event_q;
	logic          bit_tick;
	logic          stop_tick;
	logic          stop_good;
	logic          spend;

	// A sample point is reached when the countdown hits zero mid-frame.
	assign bit_tick = (bit_idx != IDX_IDLE) && (prescale == '0);
	assign stop_tick = bit_tick && (bit_idx == IDX_STOP);
	assign stop_good = stop_tick && sync_2;
	assign spend = stop_good && (credits != '0);

	// Two-flop synchronizer, idle level is high.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sync_1 <= 1'b1;
			sync_2 <= 1'b1;
		end else begin
			sync_1 <= i_serial;
			sync_2 <= sync_1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prescale <= '0;
			bit_idx <= IDX_IDLE;
		end else if (bit_idx == IDX_IDLE) begin
			// Falling edge, wait half a bit to confirm.
			if (!sync_2) begin
				prescale <= PW'(HALF_BIT - 1);
				bit_idx <= IDX_START;
			end
		end else if ((bit_idx == IDX_START) && sync_2) begin
			// Glitch, line returned high before mid start bit.
			bit_idx <= IDX_IDLE;
		end else if (prescale != '0) begin
			prescale <= prescale - 1'b1;
		end else begin
			prescale <= PW'(CLKS_PER_BIT - 1);
			bit_idx <= bit_idx - 1'b1;
		end
	end

	// Data bits arrive LSB first.
	always_ff @(posedge i_clock) begin
		if (bit_tick && (bit_idx > IDX_STOP) && (bit_idx < IDX_START)) begin
			shift_data <= {sync_2, shift_data[7:1]};
		end
	end

	// Push and events are registered off the stop sample.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			push_q <= 1'b0;
			event_q <= '0;
		end else begin
			push_q <= spend;
			event_q.accepted <= spend;
			event_q.overrun <= stop_good && (credits == '0);
			event_q.framing_err <= stop_tick && !sync_2;
			event_q.soft_char <= stop_good && (shift_data == 8'hFF);
		end
	end

	// One credit per push, one back per FIFO pop.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			credits <= CW'(CREDITS);
		end else if (spend && !i_credit_return) begin
			credits <= credits - 1'b1;
		end else if (!spend && i_credit_return) begin
			credits <= credits + 1'b1;
		end
	end

	// Shift register holds the byte until the next frame's first data bit.
	assign o_frame = '{valid: push_q, data: shift_data};
	assign o_event = event_q;

endmodule

// ==== common/uart_rx_pkg.sv ====
// Types shared by the receive pipeline; the status layout is fixed at three flags in the low bits.
package uart_rx_pkg;

	// Bus read request, held high by the bus until o_ready is seen.
	typedef struct packed {
		logic       req;
		logic [1:0] addr;
	} bus_req_t;

	// Push from the frame receiver into the FIFO.
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} rx_frame_t;

	// One-cycle event pulses from the frame receiver.
	typedef struct packed {
		logic accepted;
		logic overrun;
		logic framing_err;
		// FF byte with a good stop bit.
		logic soft_char;
	} rx_event_t;

	// Status register word, bit 0 first from the bottom.
	typedef struct packed {
		logic [28:0] reserved;
		logic        framing_err;
		logic        fifo_empty;
		logic        overrun;
	} status_bits_t;

endpackage

// ==== common/uart_rx_defines.svh ====
// UART_CLKS_PER_BIT must be even and at least 8; the FIFO depth is also the receiver's credit count.
`ifndef UART_RX_DEFINES_SVH
`define UART_RX_DEFINES_SVH

// Clock cycles per serial bit.
`define UART_CLKS_PER_BIT 16

// Receive FIFO depth.
// Also the number of credits the receiver starts with.
`define UART_FIFO_DEPTH 8

// Register map, word addresses on the 2-bit bus.
`define UART_ADDR_DATA 2'd0
`define UART_ADDR_STATUS 2'd1

`endif
